/* verilog/router_opl_settings.svh */
/*
  Build-time sizes for the output port lookup stage
  Port fields are 8 bits wide in NetFPGA numbering, even bits physical, odd bits CPU
  FIFO depth is a power of two, nearly full sits one entry below full
  Register offsets are word addresses on the simple strobe bus
*/
`ifndef ROUTER_OPL_SETTINGS_SVH
`define ROUTER_OPL_SETTINGS_SVH

// Stream geometry
`define OPL_DATA_WIDTH        256
`define OPL_TUSER_WIDTH       128
`define OPL_SRC_PORT_POS      16   // Source port byte in tuser
`define OPL_DST_PORT_POS      24   // Destination port byte in tuser

// Input buffer, log2 of entries
`define OPL_FIFO_DEPTH_BITS   2

// Register bus
`define OPL_REG_WIDTH         32
`define OPL_REG_ADDR_BITS     2

// Word offsets
`define OPL_REG_RESET          0   // Write only, bit 0 clears counters
`define OPL_REG_FWD_COUNT      1
`define OPL_REG_CPU_COUNT      2
`define OPL_REG_UNMAPPED_COUNT 3

`endif

/* verilog/router_opl_pkg.sv */
/*
  Shared types for the output port lookup stage
  Widths follow router_opl_settings.svh, so that header must be on the include path
  Beat field order matches the packed order tlast, tuser, tstrb, tdata
*/
`default_nettype none

`include "router_opl_settings.svh"

package router_opl_pkg;

  // One stream beat, sideband and payload together
  typedef struct packed {
    logic                          tlast;  // End of packet
    logic [`OPL_TUSER_WIDTH-1:0]   tuser;  // Lengths and port fields
    logic [`OPL_DATA_WIDTH/8-1:0]  tstrb;  // Byte enables
    logic [`OPL_DATA_WIDTH-1:0]    tdata;
  } axis_beat_t;

  // One-hot port mask
  // Even bits are MAC ports, odd bits the matching CPU queues
  typedef logic [7:0] port_mask_t;

  // Register request, cs is a single-cycle strobe
  typedef struct packed {
    logic                            cs;
    logic                            rnw;    // 1 read, 0 write
    logic [`OPL_REG_ADDR_BITS-1:0]   addr;   // Word address
    logic [`OPL_REG_WIDTH-1:0]       wdata;
  } reg_req_t;

  // Register response, one cycle after cs
  typedef struct packed {
    logic                            rd_ack;
    logic                            wr_ack;
    logic                            error;  // Bad address or write to read-only
    logic [`OPL_REG_WIDTH-1:0]       rdata;  // Valid with rd_ack
  } reg_rsp_t;

endpackage

`default_nettype wire

/* verilog/opl_input_fifo.sv */
/*
  Small fallthrough buffer for stream beats
  Head entry is visible combinationally while empty is low
  nearly_full rises one entry below full, so the writer stalls with one slot spare
  Writes while full and reads while empty are dropped
*/
`timescale 1ns/10ps
`default_nettype none

`include "router_opl_settings.svh"

module opl_input_fifo (
  input  wire                          AXI_ACLK,
  input  wire                          AXI_RESETN,

  input  wire router_opl_pkg::axis_beat_t wr_beat,
  input  wire                          wr_en,
  input  wire                          rd_en,

  output router_opl_pkg::axis_beat_t   rd_beat,
  output logic                         empty,
  output logic                         nearly_full
);

  import router_opl_pkg::*;

  localparam int DEPTH = 1 << `OPL_FIFO_DEPTH_BITS;

  // Occupancy levels at count width
  localparam logic [`OPL_FIFO_DEPTH_BITS:0] FULL_LEVEL =
    {1'b1, {`OPL_FIFO_DEPTH_BITS{1'b0}}};
  localparam logic [`OPL_FIFO_DEPTH_BITS:0] NEARLY_FULL_LEVEL =
    {1'b0, {`OPL_FIFO_DEPTH_BITS{1'b1}}};

  axis_beat_t                      mem [DEPTH];  // Beat storage
  logic [`OPL_FIFO_DEPTH_BITS-1:0] wr_ptr;
  logic [`OPL_FIFO_DEPTH_BITS-1:0] rd_ptr;
  logic [`OPL_FIFO_DEPTH_BITS:0]   count;        // 0 .. DEPTH
  logic                            do_wr;
  logic                            do_rd;

  assign do_wr = wr_en && (count != FULL_LEVEL);  // Guard against overrun
  assign do_rd = rd_en && !empty;

  // Storage, written at the tail
  always_ff @(posedge AXI_ACLK) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_beat;
    end
  end

  // Pointers and occupancy
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) wr_ptr <= wr_ptr + 1'b1;  // Wraps at DEPTH
      if (do_rd) rd_ptr <= rd_ptr + 1'b1;
      case ({do_wr, do_rd})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;           // Idle or simultaneous push and pop
      endcase
    end
  end

  // Fallthrough head
  assign rd_beat     = mem[rd_ptr];
  assign empty       = (count == '0);
  assign nearly_full = (count >= NEARLY_FULL_LEVEL);

endmodule

`default_nettype wire

/* verilog/opl_port_mapper.sv */
/*
  Destination port rewrite on the first beat of each packet
  Any CPU source bit sends the packet to MAC port 1 (mask 0x04)
  Physical sources are cross-mapped, highest even source bit wins
  No source bit leaves the destination field as received
  Output follows the FIFO head with no added cycles, pulses count first beats only
*/
`timescale 1ns/10ps
`default_nettype none

`include "router_opl_settings.svh"

module opl_port_mapper (
  input  wire                          AXI_ACLK,
  input  wire                          AXI_RESETN,

  input  wire router_opl_pkg::axis_beat_t fifo_beat,
  input  wire                          fifo_valid,
  output logic                         fifo_pop,

  output router_opl_pkg::axis_beat_t   m_axis_beat,
  output logic                         m_axis_tvalid,
  input  wire                          m_axis_tready,

  output logic                         fwd_pulse,
  output logic                         cpu_pulse,
  output logic                         unmapped_pulse
);

  import router_opl_pkg::*;

  localparam int PW = $bits(port_mask_t);

  typedef enum logic {
    ST_HEADER,     // Next accepted beat is a first beat
    ST_IN_PACKET
  } state_t;

  state_t     state, state_next;
  port_mask_t src_port;
  port_mask_t dst_port;     // Rewritten destination
  logic       from_cpu;
  logic       src_mapped;   // Some even source bit set
  logic       out_hs;
  logic       first_hs;     // First beat leaves this cycle

  assign src_port   = fifo_beat.tuser[`OPL_SRC_PORT_POS +: PW];
  assign from_cpu   = |{src_port[7], src_port[5], src_port[3], src_port[1]};
  assign src_mapped = |{src_port[6], src_port[4], src_port[2], src_port[0]};

  // Fixed map, checks ordered so the highest even bit wins
  always_comb begin
    dst_port = fifo_beat.tuser[`OPL_DST_PORT_POS +: PW];  // Unmapped keeps its field
    if (from_cpu)         dst_port = 8'h04;
    else if (src_port[6]) dst_port = 8'h10;
    else if (src_port[4]) dst_port = 8'h40;
    else if (src_port[2]) dst_port = 8'h01;
    else if (src_port[0]) dst_port = 8'h04;
  end

  // Output stream straight from the FIFO head
  always_comb begin
    m_axis_beat = fifo_beat;
    if (state == ST_HEADER) begin
      m_axis_beat.tuser[`OPL_DST_PORT_POS +: PW] = dst_port;
    end
  end

  assign m_axis_tvalid = fifo_valid;
  assign out_hs        = fifo_valid && m_axis_tready;
  assign fifo_pop      = out_hs;  // Pop exactly on the output handshake

  // Header / in-packet tracking
  always_comb begin
    state_next = state;
    case (state)
      ST_HEADER:    if (out_hs && !fifo_beat.tlast) state_next = ST_IN_PACKET;
      ST_IN_PACKET: if (out_hs && fifo_beat.tlast)  state_next = ST_HEADER;
      default:      state_next = ST_HEADER;
    endcase
  end

  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) state <= ST_HEADER;
    else             state <= state_next;
  end

  // Packet kind, one pulse per packet
  assign first_hs       = out_hs && (state == ST_HEADER);
  assign cpu_pulse      = first_hs && from_cpu;
  assign fwd_pulse      = first_hs && !from_cpu && src_mapped;
  assign unmapped_pulse = first_hs && !from_cpu && !src_mapped;

endmodule

`default_nettype wire

/* verilog/opl_stat_regs.sv */
/*
  Packet counters behind a simple strobe register bus
  One access per cs, answered by a single ack on the next cycle
  Counters are read only and wrap, writes to them return error
  Writing bit 0 of the reset word clears all counters, a pulse in that cycle is lost
  The requester must wait for the ack before the next cs
*/
`timescale 1ns/10ps
`default_nettype none

`include "router_opl_settings.svh"

module opl_stat_regs (
  input  wire                        AXI_ACLK,
  input  wire                        AXI_RESETN,

  input  wire router_opl_pkg::reg_req_t reg_req,
  output router_opl_pkg::reg_rsp_t   reg_rsp,

  input  wire                        fwd_pulse,
  input  wire                        cpu_pulse,
  input  wire                        unmapped_pulse
);

  localparam int RW = `OPL_REG_WIDTH;

  // Word addresses at bus width
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_RESET    = `OPL_REG_RESET;
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_FWD      = `OPL_REG_FWD_COUNT;
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_CPU      = `OPL_REG_CPU_COUNT;
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_UNMAPPED = `OPL_REG_UNMAPPED_COUNT;

  // Counter slots
  localparam int NUM_CNT      = 3;
  localparam int CNT_FWD      = 0;
  localparam int CNT_CPU      = 1;
  localparam int CNT_UNMAPPED = 2;

  logic [RW-1:0]      count [NUM_CNT];
  logic [NUM_CNT-1:0] pulse;
  logic [RW-1:0]      rd_data;     // Read mux result
  logic               addr_ok;     // Address decodes to a register
  logic               wr_err;
  logic               clear_cnt;
  logic               rd_ack_q;
  logic               wr_ack_q;
  logic               error_q;
  logic [RW-1:0]      rdata_q;

  assign pulse = {unmapped_pulse, cpu_pulse, fwd_pulse};  // Slot order above

  // Address decode and read mux
  always_comb begin
    rd_data = '0;
    addr_ok = 1'b1;
    case (reg_req.addr)
      ADDR_RESET:    rd_data = '0;                    // Write only, reads as zero
      ADDR_FWD:      rd_data = count[CNT_FWD];
      ADDR_CPU:      rd_data = count[CNT_CPU];
      ADDR_UNMAPPED: rd_data = count[CNT_UNMAPPED];
      default:       addr_ok = 1'b0;                  // Only with a wider address
    endcase
  end

  // Only the reset word takes writes
  assign wr_err    = !addr_ok || (reg_req.addr != ADDR_RESET);
  assign clear_cnt = reg_req.cs && !reg_req.rnw && (reg_req.addr == ADDR_RESET)
                     && reg_req.wdata[0];

  // Counters, clear takes priority over a same-cycle pulse
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN || clear_cnt) begin
      for (int i = 0; i < NUM_CNT; i++) begin
        count[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_CNT; i++) begin
        if (pulse[i]) count[i] <= count[i] + 1'b1;
      end
    end
  end

  // Acks one cycle after cs
  always_ff @(posedge AXI_ACLK) begin
    if (!AXI_RESETN) begin
      rd_ack_q <= 1'b0;
      wr_ack_q <= 1'b0;
      error_q  <= 1'b0;
    end else begin
      rd_ack_q <= reg_req.cs && reg_req.rnw;
      wr_ack_q <= reg_req.cs && !reg_req.rnw;
      error_q  <= reg_req.cs && (reg_req.rnw ? !addr_ok : wr_err);
    end
  end

  // Read data held until the next read
  always_ff @(posedge AXI_ACLK) begin
    if (reg_req.cs && reg_req.rnw) rdata_q <= rd_data;
  end

  assign reg_rsp = '{rd_ack: rd_ack_q, wr_ack: wr_ack_q, error: error_q, rdata: rdata_q};

endmodule

`default_nettype wire

/* verilog/router_output_port_lookup.sv */
/*
  Output port lookup stage, input FIFO then port rewrite, plus packet counters
  One cycle from input acceptance to output when the FIFO is empty
  Input ready drops at three buffered beats while the output is stalled
  Packet order is always kept
*/
`timescale 1ns/10ps
`default_nettype none

module router_output_port_lookup (
  input  wire                           AXI_ACLK,
  input  wire                           AXI_RESETN,

  // From the RX queues
  input  wire router_opl_pkg::axis_beat_t  s_axis_beat,
  input  wire                           s_axis_tvalid,
  output logic                          s_axis_tready,

  // To the output queues
  output router_opl_pkg::axis_beat_t    m_axis_beat,
  output logic                          m_axis_tvalid,
  input  wire                           m_axis_tready,

  // Register access
  input  wire router_opl_pkg::reg_req_t    reg_req,
  output router_opl_pkg::reg_rsp_t      reg_rsp
);

  import router_opl_pkg::*;

  axis_beat_t fifo_beat;        // FIFO head
  logic       fifo_empty;
  logic       fifo_nearly_full;
  logic       fifo_pop;
  logic       fwd_pulse;
  logic       cpu_pulse;
  logic       unmapped_pulse;

  assign s_axis_tready = !fifo_nearly_full;

  opl_input_fifo u_input_fifo (
    .AXI_ACLK    (AXI_ACLK),
    .AXI_RESETN  (AXI_RESETN),
    .wr_beat     (s_axis_beat),
    .wr_en       (s_axis_tvalid && s_axis_tready),  // Input handshake
    .rd_en       (fifo_pop),
    .rd_beat     (fifo_beat),
    .empty       (fifo_empty),
    .nearly_full (fifo_nearly_full)
  );

  opl_port_mapper u_port_mapper (
    .AXI_ACLK       (AXI_ACLK),
    .AXI_RESETN     (AXI_RESETN),
    .fifo_beat      (fifo_beat),
    .fifo_valid     (!fifo_empty),
    .fifo_pop       (fifo_pop),
    .m_axis_beat    (m_axis_beat),
    .m_axis_tvalid  (m_axis_tvalid),
    .m_axis_tready  (m_axis_tready),
    .fwd_pulse      (fwd_pulse),
    .cpu_pulse      (cpu_pulse),
    .unmapped_pulse (unmapped_pulse)
  );

  opl_stat_regs u_stat_regs (
    .AXI_ACLK       (AXI_ACLK),
    .AXI_RESETN     (AXI_RESETN),
    .reg_req        (reg_req),
    .reg_rsp        (reg_rsp),
    .fwd_pulse      (fwd_pulse),
    .cpu_pulse      (cpu_pulse),
    .unmapped_pulse (unmapped_pulse)
  );

endmodule

`default_nettype wire

/* dv/tb_router_opl.sv */
/*
  Directed testbench for the output port lookup stage
  Inputs change on the falling edge and outputs are sampled at either clock edge
  Expected beats come from a reference port map and are checked by an output monitor
  Payloads are random with a fixed seed
  The watchdog scales with the total beat count
*/
`timescale 1ns/10ps
`default_nettype none

`include "router_opl_settings.svh"

module tb_router_opl;

  import router_opl_pkg::*;

  localparam int TOTAL_BEATS     = 46;                      // Stream beats plus register accesses
  localparam int WATCHDOG_CYCLES = (TOTAL_BEATS + 4) * 20;  // 20 cycles per beat plus reset
  localparam int DRAIN_LIMIT     = 50;
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_RESET    = `OPL_REG_RESET;
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_FWD      = `OPL_REG_FWD_COUNT;
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_CPU      = `OPL_REG_CPU_COUNT;
  localparam logic [`OPL_REG_ADDR_BITS-1:0] ADDR_UNMAPPED = `OPL_REG_UNMAPPED_COUNT;

  logic       AXI_ACLK;
  logic       AXI_RESETN;
  axis_beat_t s_axis_beat;
  logic       s_axis_tvalid;
  logic       s_axis_tready;
  axis_beat_t m_axis_beat;
  logic       m_axis_tvalid;
  logic       m_axis_tready;
  reg_req_t   reg_req;
  reg_rsp_t   reg_rsp;

  axis_beat_t  exp_q [$];   // Beats still due at the output
  axis_beat_t  mon_exp;
  logic [31:0] exp_fwd;     // Packets sent by kind
  logic [31:0] exp_cpu;
  logic [31:0] exp_unm;
  int          errors;
  int          pass_count;
  int          fail_count;

  router_output_port_lookup DUT (
    .AXI_ACLK      (AXI_ACLK),
    .AXI_RESETN    (AXI_RESETN),
    .s_axis_beat   (s_axis_beat),
    .s_axis_tvalid (s_axis_tvalid),
    .s_axis_tready (s_axis_tready),
    .m_axis_beat   (m_axis_beat),
    .m_axis_tvalid (m_axis_tvalid),
    .m_axis_tready (m_axis_tready),
    .reg_req       (reg_req),
    .reg_rsp       (reg_rsp)
  );

  initial begin
    AXI_ACLK = 1'b0;
    forever #4 AXI_ACLK = ~AXI_ACLK;  // 8 ns period
  end

  // Destination for one physical source bit
  function automatic port_mask_t even_dest(int bit_pos);
    case (bit_pos)
      0:       return 8'h04;
      2:       return 8'h01;
      4:       return 8'h40;
      default: return 8'h10;
    endcase
  endfunction

  // Reference port map
  function automatic port_mask_t ref_dst(port_mask_t src, port_mask_t dst);
    port_mask_t result;
    result = dst;                                 // Field kept with no source bit
    if ((src & 8'hAA) != 8'h00) begin
      result = 8'h04;                             // Any CPU port
    end else begin
      for (int b = 0; b < 8; b += 2) begin
        if (src[b]) result = even_dest(b);        // Ascending so the highest even bit lands last
      end
    end
    return result;
  endfunction

  function automatic axis_beat_t make_beat(port_mask_t src, port_mask_t dst, logic last);
    axis_beat_t b;
    for (int i = 0; i < 8; i++) begin
      b.tdata[i*32 +: 32] = $urandom;
    end
    for (int i = 0; i < 4; i++) begin
      b.tuser[i*32 +: 32] = $urandom;
    end
    b.tstrb = $urandom;
    b.tuser[`OPL_SRC_PORT_POS +: 8] = src;
    b.tuser[`OPL_DST_PORT_POS +: 8] = dst;
    b.tlast = last;
    return b;
  endfunction

  // Packet kind for the counters
  task automatic tally_kind(input port_mask_t src);
    if ((src & 8'hAA) != 8'h00)      exp_cpu = exp_cpu + 1;
    else if ((src & 8'h55) != 8'h00) exp_fwd = exp_fwd + 1;
    else                             exp_unm = exp_unm + 1;
  endtask

  // Starts on a falling edge and returns on the one after acceptance
  task automatic push_beat(input axis_beat_t b);
    s_axis_beat   = b;
    s_axis_tvalid = 1'b1;
    @(posedge AXI_ACLK);
    while (!s_axis_tready) @(posedge AXI_ACLK);
    @(negedge AXI_ACLK);
  endtask

  task automatic send_packet(input port_mask_t src, input port_mask_t dst, input int nbeats);
    axis_beat_t b;
    axis_beat_t e;
    for (int i = 0; i < nbeats; i++) begin
      if (i == 0) b = make_beat(src, dst, nbeats == 1);
      else        b = make_beat(8'($urandom), 8'($urandom), i == nbeats - 1);
      e = b;
      if (i == 0) e.tuser[`OPL_DST_PORT_POS +: 8] = ref_dst(src, dst);  // First beat only
      exp_q.push_back(e);
      push_beat(b);
    end
    s_axis_tvalid = 1'b0;
    tally_kind(src);
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < DRAIN_LIMIT) begin
      @(negedge AXI_ACLK);
      n++;
    end
    if (exp_q.size() != 0) begin
      $display("%0d expected beats never reached the output", exp_q.size());
      errors++;
      exp_q.delete();
    end
  endtask

  // One register access with the ack due at the next falling edge
  task automatic reg_access(input logic rnw, input logic [`OPL_REG_ADDR_BITS-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    reg_req.cs    = 1'b1;
    reg_req.rnw   = rnw;
    reg_req.addr  = addr;
    reg_req.wdata = wdata;
    @(negedge AXI_ACLK);
    if (reg_rsp.rd_ack !== rnw || reg_rsp.wr_ack !== !rnw) begin
      $display("Access to word %0d was not acknowledged on the cycle after cs", addr);
      errors++;
    end
    rdata      = reg_rsp.rdata;
    err        = reg_rsp.error;
    reg_req.cs = 1'b0;
    @(negedge AXI_ACLK);
    if (reg_rsp.rd_ack || reg_rsp.wr_ack) begin
      $display("Ack for word %0d lasted more than one cycle", addr);
      errors++;
    end
  endtask

  task automatic read_expect(input logic [`OPL_REG_ADDR_BITS-1:0] addr,
                             input logic [31:0] exp, input string name);
    logic [31:0] rd;
    logic        err;
    reg_access(1'b1, addr, 32'h0, rd, err);
    if (rd !== exp) begin
      $display("MISMATCH %s: expected %h, got %h", name, exp, rd);
      errors++;
    end
    if (err !== 1'b0) begin
      $display("MISMATCH reg_rsp.error on %s read: expected 0, got %h", name, err);
      errors++;
    end
  endtask

  task automatic close_test(input string name, input int errs_before);
    if (errors == errs_before) begin
      pass_count++;
      $display("%s: PASS", name);
    end else begin
      fail_count++;
      $display("%s: FAIL, %0d errors", name, errors - errs_before);
    end
  endtask

  task automatic after_reset_state();
    int e0;
    e0 = errors;
    if (m_axis_tvalid !== 1'b0) begin
      $display("MISMATCH m_axis_tvalid: expected 0, got %h", m_axis_tvalid);
      errors++;
    end
    if (s_axis_tready !== 1'b1) begin
      $display("MISMATCH s_axis_tready: expected 1, got %h", s_axis_tready);
      errors++;
    end
    if (reg_rsp.rd_ack || reg_rsp.wr_ack || reg_rsp.error) begin
      $display("Register response active straight after reset");
      errors++;
    end
    read_expect(ADDR_RESET, 32'h0, "reset_reg");
    read_expect(ADDR_FWD, 32'h0, "fwd_count");
    read_expect(ADDR_CPU, 32'h0, "cpu_count");
    read_expect(ADDR_UNMAPPED, 32'h0, "unmapped_count");
    close_test("after_reset", e0);
  endtask

  task automatic physical_port_map();
    int         e0;
    axis_beat_t b;
    axis_beat_t e;
    e0 = errors;
    m_axis_tready = 1'b1;
    for (int s = 0; s < 8; s += 2) begin
      send_packet(8'(1 << s), 8'($urandom), 3);
      wait_drain();
    end
    send_packet(8'h14, 8'($urandom), 3);           // Bits 2 and 4 set so bit 4 wins
    wait_drain();
    // Single beat into an empty FIFO
    b = make_beat(8'h04, 8'h00, 1'b1);
    e = b;
    e.tuser[`OPL_DST_PORT_POS +: 8] = ref_dst(8'h04, 8'h00);
    exp_q.push_back(e);
    tally_kind(8'h04);
    s_axis_beat   = b;
    s_axis_tvalid = 1'b1;
    @(posedge AXI_ACLK);
    if (!s_axis_tready) begin
      $display("MISMATCH s_axis_tready: expected 1, got %h", s_axis_tready);
      errors++;
    end
    @(negedge AXI_ACLK);
    s_axis_tvalid = 1'b0;
    if (m_axis_tvalid !== 1'b1) begin
      $display("MISMATCH m_axis_tvalid: expected 1, got %h", m_axis_tvalid);
      errors++;
    end
    wait_drain();
    close_test("physical_port_map", e0);
  endtask

  task automatic cpu_and_unmapped();
    int e0;
    e0 = errors;
    send_packet(8'h02, 8'($urandom), 2);
    send_packet(8'h08, 8'($urandom), 2);
    send_packet(8'h21, 8'($urandom), 2);           // CPU bit beats even bit
    send_packet(8'h80, 8'($urandom), 2);
    send_packet(8'h00, 8'h5a, 2);                  // Field must survive
    send_packet(8'h00, 8'hc3, 1);
    wait_drain();
    close_test("cpu_and_unmapped", e0);
  endtask

  task automatic backpressure_order();
    int         e0;
    int         idx;
    int         stalls;
    axis_beat_t beats [6];
    axis_beat_t e;
    port_mask_t src;
    e0            = errors;
    m_axis_tready = 1'b0;
    for (int i = 0; i < 6; i++) begin
      src = (i < 3) ? 8'h40 : 8'h08;
      if (i % 3 == 0) beats[i] = make_beat(src, 8'($urandom), 1'b0);
      else            beats[i] = make_beat(8'($urandom), 8'($urandom), i % 3 == 2);
      e = beats[i];
      if (i % 3 == 0) e.tuser[`OPL_DST_PORT_POS +: 8] = ref_dst(src, beats[i].tuser[
        `OPL_DST_PORT_POS +: 8]);
      exp_q.push_back(e);
    end
    idx    = 0;
    stalls = 0;
    while (idx < 6) begin
      s_axis_beat   = beats[idx];
      s_axis_tvalid = 1'b1;
      @(posedge AXI_ACLK);
      if (s_axis_tready) idx++;
      else               stalls++;
      @(negedge AXI_ACLK);
      if (stalls == 6 && !m_axis_tready) begin    // Stalled long enough so check and release
        if (idx != 3) begin
          $display("MISMATCH accepted beats: expected %h, got %h", 3, idx);
          errors++;
        end
        if (s_axis_tready !== 1'b0) begin
          $display("MISMATCH s_axis_tready: expected 0, got %h", s_axis_tready);
          errors++;
        end
        // Head beat held at the output while stalled
        if (m_axis_tvalid !== 1'b1) begin
          $display("MISMATCH m_axis_tvalid: expected 1, got %h", m_axis_tvalid);
          errors++;
        end
        if (m_axis_beat !== exp_q[0]) begin
          $display("MISMATCH m_axis_beat: expected %h, got %h", exp_q[0], m_axis_beat);
          errors++;
        end
        m_axis_tready = 1'b1;
      end
    end
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b1;
    if (stalls < 6) begin
      $display("s_axis_tready never dropped while the output was stalled");
      errors++;
    end
    tally_kind(8'h40);
    tally_kind(8'h08);
    wait_drain();
    close_test("backpressure_order", e0);
  endtask

  task automatic counter_registers();
    int          e0;
    logic [31:0] rd;
    logic        err;
    e0 = errors;
    read_expect(ADDR_FWD, exp_fwd, "fwd_count");
    read_expect(ADDR_CPU, exp_cpu, "cpu_count");
    read_expect(ADDR_UNMAPPED, exp_unm, "unmapped_count");
    reg_access(1'b0, ADDR_FWD, 32'h0000_0005, rd, err);   // Counters are read only
    if (err !== 1'b1) begin
      $display("MISMATCH reg_rsp.error on fwd_count write: expected 1, got %h", err);
      errors++;
    end
    read_expect(ADDR_FWD, exp_fwd, "fwd_count");
    reg_access(1'b0, ADDR_RESET, 32'h0000_0001, rd, err);
    if (err !== 1'b0) begin
      $display("MISMATCH reg_rsp.error on reset write: expected 0, got %h", err);
      errors++;
    end
    read_expect(ADDR_FWD, 32'h0, "fwd_count");
    read_expect(ADDR_CPU, 32'h0, "cpu_count");
    read_expect(ADDR_UNMAPPED, 32'h0, "unmapped_count");
    close_test("counter_registers", e0);
  endtask

  // Output monitor comparing every accepted beat in order
  always @(posedge AXI_ACLK) begin
    if (AXI_RESETN && m_axis_tvalid && m_axis_tready) begin
      if (exp_q.size() == 0) begin
        $display("Output beat appeared with none expected, tuser %h", m_axis_beat.tuser);
        errors++;
      end else begin
        mon_exp = exp_q.pop_front();
        if (m_axis_beat !== mon_exp) begin
          $display("MISMATCH m_axis_beat: expected %h, got %h", mon_exp, m_axis_beat);
          errors++;
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge AXI_ACLK);
    $display("Run stopped by the watchdog after %0d cycles", WATCHDOG_CYCLES);
    $display("Verification failed");
    $finish;
  end

  initial begin
    void'($urandom(44217));
    AXI_RESETN    = 1'b0;
    s_axis_beat   = '0;
    s_axis_tvalid = 1'b0;
    m_axis_tready = 1'b0;
    reg_req       = '0;
    exp_fwd       = '0;
    exp_cpu       = '0;
    exp_unm       = '0;
    errors        = 0;
    pass_count    = 0;
    fail_count    = 0;
    repeat (4) @(posedge AXI_ACLK);
    @(negedge AXI_ACLK);
    AXI_RESETN = 1'b1;

    after_reset_state();
    physical_port_map();
    cpu_and_unmapped();
    backpressure_order();
    counter_registers();

    $display("Tests passed: %0d, failed: %0d, errors: %0d", pass_count, fail_count, errors);
    if (fail_count == 0 && errors == 0) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+verilog
verilog/router_opl_pkg.sv
verilog/opl_input_fifo.sv
verilog/opl_port_mapper.sv
verilog/opl_stat_regs.sv
verilog/router_output_port_lookup.sv
dv/tb_router_opl.sv

/* run_sim.sh */
#!/bin/sh
# Builds the output port lookup testbench with Verilator and runs it.
# Exit status is 0 only when the log holds the pass message.

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir

verilator --binary --timing -j 0 -f filelist.f --top-module tb_router_opl \
  -o sim_tb > "$BUILD_LOG" 2>&1 \
  && ./obj_dir/sim_tb > "$SIM_LOG" 2>&1 \
  || { echo "Build or simulation error"; cat "$BUILD_LOG"; exit 1; }

cat "$SIM_LOG"

grep -q "Verification passed" "$SIM_LOG" \
  && echo "Simulation PASSED" \
  || { echo "Simulation FAILED"; exit 1; }
